//--- source/mulSettings.svh
`ifndef MUL_SETTINGS_SVH
`define MUL_SETTINGS_SVH

// Operand width of the multiplier
`define MUL_WIDTH 8

// Full product width
`define PROD_WIDTH 16

// Result queue entries
// Also the number of credits the sender starts with
`define QUEUE_DEPTH 4

// Credits granted by the sink after reset
`define SINK_CREDITS 2

`endif

//--- source/mulPkg.sv
`default_nettype none

`include "mulSettings.svh"

package mulPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Datapath types
    ////////////////////////////////////////////////////////////////////////////

    // One operand
    typedef logic [`MUL_WIDTH-1:0] operandT;

    // One product
    typedef logic [`PROD_WIDTH-1:0] productT;

    // One partial-product row, A[i] & B
    typedef logic [`MUL_WIDTH-1:0] ppRowT;

    // Folded symmetric pairs, one bit per pair
    // Row 2 has one pair, rows 3 to 7 have 3, 4, 5, 6, 5
    typedef logic [23:0] pairVecT;

    // Diagonal terms and the pairs left unfolded
    typedef logic [15:0] edgeVecT;

    // Decode to execute bundle
    // Edge bits on top, then generate bits, propagate bits at the bottom
    typedef logic [$bits(edgeVecT)+2*$bits(pairVecT)-1:0] pgPairT;

    // Final K and J rows ahead of the prefix adder
    typedef logic [`PROD_WIDTH-1:0] reduceRowT;

endpackage

`default_nettype wire

//--- source/ppDecode.sv
`timescale 1ns/1ps
`default_nettype none

`include "mulSettings.svh"

module ppDecode (
    input  logic            clk,
    input  logic            rst,
    input  logic            inValid,
    input  mulPkg::operandT inA,
    input  mulPkg::operandT inB,
    output logic            pgValid,
    output mulPkg::pgPairT  pgBits
);

    // Row r holds A[r] & B, so pp[r][c] is A[r] & B[c]
    mulPkg::ppRowT pp [`MUL_WIDTH];
    // Transposed rows, ppT[c][r] equals pp[r][c]
    mulPkg::ppRowT ppT [`MUL_WIDTH];

    mulPkg::pairVecT pairA;
    mulPkg::pairVecT pairB;
    mulPkg::edgeVecT edgeBits;
    mulPkg::pgPairT  pgNext;

    ////////////////////////////////////////////////////////////////////////////
    // Partial products
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int r = 0; r < `MUL_WIDTH; r++) begin
            pp[r]  = {`MUL_WIDTH{inA[r]}} & inB;
            ppT[r] = {`MUL_WIDTH{inB[r]}} & inA;
        end
    end

    // Lower-triangle terms of rows 7 down to 2
    assign pairA = {pp[7][4:0], pp[6][5:0], pp[5][4:0], pp[4][3:0], pp[3][2:0], pp[2][1]};
    // Mirror terms, same positions
    assign pairB = {ppT[7][4:0], ppT[6][5:0], ppT[5][4:0], ppT[4][3:0], ppT[3][2:0],
                    ppT[2][1]};

    // Diagonal bits plus the pairs that execute consumes one by one
    assign edgeBits = {pp[6][7], pp[7][6], pp[5][7], pp[7][5],
                       pp[7][7], pp[6][6], pp[5][5], pp[4][4],
                       pp[3][3], pp[2][2], pp[1][1], pp[0][2],
                       pp[2][0], pp[0][1], pp[1][0], pp[0][0]};

    // Generate is AND, propagate is OR of each pair
    assign pgNext = {edgeBits, pairA & pairB, pairA | pairB};

    ////////////////////////////////////////////////////////////////////////////
    // Stage register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            pgValid <= 1'b0;
        end else begin
            pgValid <= inValid;
        end
    end

    // Payload only, valid qualifies it
    always_ff @(posedge clk) begin
        pgBits <= pgNext;
    end

endmodule

`default_nettype wire

//--- source/approxReduce.sv
`timescale 1ns/1ps
`default_nettype none

module approxReduce (
    input  logic              clk,
    input  logic              rst,
    input  logic              pgValid,
    input  mulPkg::pgPairT    pgBits,
    output logic              rowValid,
    output mulPkg::reduceRowT rowK,
    output mulPkg::reduceRowT rowJ
);

    ////////////////////////////////////////////////////////////////////////////
    // Cell library, results packed as {carry, sum}
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [1:0] halfAdd(input logic a, input logic b);
        return {a & b, a ^ b};
    endfunction

    function automatic logic [1:0] fullAdd(input logic a, input logic b, input logic cin);
        return {(a & b) | (cin & (a ^ b)), a ^ b ^ cin};
    endfunction

    // Sum by OR instead of XOR
    function automatic logic [1:0] approxHalf(input logic a, input logic b);
        return {a & b, a | b};
    endfunction

    // First two inputs merged by OR
    function automatic logic [1:0] approxFull(input logic a, input logic b, input logic cin);
        logic w;
        w = a | b;
        return {w & cin, w ^ cin};
    endfunction

    // Approximate 4:2, no carry out
    function automatic logic [1:0] approxComp(input logic x1, input logic x2,
                                              input logic x3, input logic x4);
        logic c1;
        logic c3;
        c1 = x1 & x2;
        c3 = x3 & x4;
        return {c1 | c3, (x1 ^ x2) | (x3 ^ x4) | (c1 & c3)};
    endfunction

    // Exact 4:2 with carry-in tied low, {cout, carry, sum}
    function automatic logic [2:0] exactComp(input logic a1, input logic a2,
                                             input logic a3, input logic a4);
        logic [1:0] low;
        low = fullAdd(a1, a2, a3);
        return {low[1], low[0] & a4, low[0] ^ a4};
    endfunction

    mulPkg::pairVecT propBits;
    mulPkg::pairVecT genBits;
    mulPkg::edgeVecT edgeBits;

    // Folded pairs per row
    logic [4:0] p7, g7, p5, g5;
    logic [5:0] p6, g6;
    logic [3:0] p4, g4;
    logic [2:0] p3, g3;
    logic       p21, g21;

    // Single partial products, ppRC is A[R] & B[C]
    logic pp00, pp10, pp01, pp20, pp02, pp11, pp22, pp33;
    logic pp44, pp55, pp66, pp77, pp75, pp57, pp76, pp67;

    logic s1, c1, s4, c4, s5, c5, s6, c6, s7, c7;
    logic s8, s9, s10, s11, s12;
    logic c12;
    logic [7:3]  gOr;
    logic [11:8] gEx;
    logic [8:1]  ce;
    logic        compCout;
    logic [5:1]  cer;
    logic [12:8] cRes;
    logic [14:3] x, y;
    logic        kTop;

    assign {edgeBits, genBits, propBits} = pgBits;
    assign {p7, p6, p5, p4, p3, p21} = propBits;
    assign {g7, g6, g5, g4, g3, g21} = genBits;
    assign {pp67, pp76, pp57, pp75, pp77, pp66, pp55, pp44,
            pp33, pp22, pp11, pp02, pp20, pp01, pp10, pp00} = edgeBits;

    ////////////////////////////////////////////////////////////////////////////
    // Columns 3 to 7, approximate
    ////////////////////////////////////////////////////////////////////////////

    assign {c4, s4} = approxHalf(p4[0], p3[1]);
    assign {c5, s5} = approxFull(p5[0], p4[1], p3[2]);
    assign {c6, s6} = approxComp(p6[0], p5[1], p4[2], pp33);
    assign {c7, s7} = approxComp(p7[0], p6[1], p5[2], p4[3]);

    // Generate bits of a column merged by plain OR
    assign gOr[3] = g3[0] | g21;
    assign gOr[4] = g4[0] | g3[1];
    assign gOr[5] = g5[0] | g4[1] | g3[2];
    assign gOr[6] = g6[0] | g5[1] | g4[2];
    assign gOr[7] = g7[0] | g6[1] | g5[2] | g4[3];

    ////////////////////////////////////////////////////////////////////////////
    // Columns 8 and up, exact
    ////////////////////////////////////////////////////////////////////////////

    assign {compCout, ce[1], s8} = exactComp(p7[1], p6[2], p5[3], pp44);
    assign {ce[2], gEx[8]}  = fullAdd(g7[1], g6[2], g5[3]);
    assign {ce[3], s9}      = fullAdd(p7[2], p6[3], p5[4]);
    assign {ce[4], gEx[9]}  = fullAdd(g7[2], g6[3], g5[4]);
    assign {ce[5], s10}     = fullAdd(p7[3], p6[4], pp55);
    assign {ce[6], gEx[10]} = halfAdd(g7[3], g6[4]);
    assign {ce[7], s11}     = halfAdd(p7[4], p6[5]);
    assign {ce[8], gEx[11]} = halfAdd(g7[4], g6[5]);
    // Column 12 pair, carry goes on to column 13
    assign {c12, s12} = halfAdd(pp75, pp57);

    // Carry chain across columns 8 to 12
    assign {cer[1], cRes[8]}  = fullAdd(ce[1], ce[2], compCout);
    assign {cer[2], cRes[9]}  = fullAdd(ce[3], ce[4], cer[1]);
    assign {cer[3], cRes[10]} = fullAdd(ce[5], ce[6], cer[2]);
    assign {cer[4], cRes[11]} = fullAdd(ce[7], ce[8], cer[3]);
    assign {cer[5], cRes[12]} = halfAdd(c12, cer[4]);

    ////////////////////////////////////////////////////////////////////////////
    // Row simplification into K and J
    ////////////////////////////////////////////////////////////////////////////

    assign {c1, s1} = approxHalf(pp20, pp02);
    assign y[3] = c1;
    assign {y[4], x[3]}   = approxFull(p3[0], p21, gOr[3]);
    assign {y[5], x[4]}   = approxFull(s4, pp22, gOr[4]);
    assign {y[6], x[5]}   = approxFull(s5, gOr[5], c4);
    assign {y[7], x[6]}   = approxFull(s6, gOr[6], c5);
    assign {y[8], x[7]}   = approxFull(s7, gOr[7], c6);
    assign {y[9], x[8]}   = fullAdd(s8, gEx[8], c7);
    assign {y[10], x[9]}  = fullAdd(s9, gEx[9], cRes[8]);
    assign {y[11], x[10]} = fullAdd(s10, gEx[10], cRes[9]);
    assign {y[12], x[11]} = fullAdd(s11, gEx[11], cRes[10]);
    assign {y[13], x[12]} = fullAdd(s12, cRes[11], pp66);
    assign {y[14], x[13]} = fullAdd(pp76, pp67, cRes[12]);
    assign {kTop, x[14]}  = halfAdd(pp77, cer[5]);

    always_ff @(posedge clk) begin
        if (rst) begin
            rowValid <= 1'b0;
        end else begin
            rowValid <= pgValid;
        end
    end

    // Bits 0 to 2 pass straight into the rows
    always_ff @(posedge clk) begin
        rowK <= {kTop, x, s1, pp10, pp00};
        rowJ <= {1'b0, y, pp11, pp01, 1'b0};
    end

endmodule

`default_nettype wire

//--- source/prefixResult.sv
`timescale 1ns/1ps
`default_nettype none

`include "mulSettings.svh"

module prefixResult (
    input  logic              clk,
    input  logic              rst,
    input  logic              rowValid,
    input  mulPkg::reduceRowT rowK,
    input  mulPkg::reduceRowT rowJ,
    output logic              sumValid,
    output mulPkg::productT   sum
);

    localparam int W      = `PROD_WIDTH;
    localparam int LEVELS = $clog2(W);

    // Group generate per level, level 0 is the bitwise term
    logic [W-1:0] gLvl [LEVELS+1];
    // Group propagate, not needed after the last level
    logic [W-1:0] pLvl [LEVELS];
    mulPkg::productT sumNext;

    assign gLvl[0] = rowK & rowJ;
    assign pLvl[0] = rowK ^ rowJ;

    ////////////////////////////////////////////////////////////////////////////
    // Kogge-Stone tree
    ////////////////////////////////////////////////////////////////////////////

    for (genvar lvl = 1; lvl <= LEVELS; lvl++) begin : gLevel
        // Span doubles every level
        localparam int D = 1 << (lvl - 1);

        for (genvar i = 0; i < W; i++) begin : gBit
            if (i < D) begin : gPass
                // Prefix already complete
                assign gLvl[lvl][i] = gLvl[lvl-1][i];
            end else begin : gCell
                assign gLvl[lvl][i] = gLvl[lvl-1][i] | (pLvl[lvl-1][i] & gLvl[lvl-1][i-D]);
            end

            if (lvl < LEVELS) begin : gProp
                if (i >= 2 * D) begin : gBlack
                    assign pLvl[lvl][i] = pLvl[lvl-1][i] & pLvl[lvl-1][i-D];
                end else begin : gGrey
                    // Group reaches bit 0, no carry-in to propagate
                    assign pLvl[lvl][i] = 1'b0;
                end
            end
        end
    end

    // Carry into bit i is the prefix generate of bit i-1
    // Carry out of the top bit is dropped
    assign sumNext = pLvl[0] ^ {gLvl[LEVELS][W-2:0], 1'b0};

    always_ff @(posedge clk) begin
        if (rst) begin
            sumValid <= 1'b0;
        end else begin
            sumValid <= rowValid;
        end
    end

    always_ff @(posedge clk) begin
        sum <= sumNext;
    end

    // Whole pipeline must deliver clean data with its valid
    assert property (@(posedge clk) disable iff (rst) sumValid |-> !$isunknown(sum))
        else $error("prefixResult: unknown sum while sumValid");

endmodule

`default_nettype wire

//--- source/creditQueue.sv
`timescale 1ns/1ps
`default_nettype none

`include "mulSettings.svh"

module creditQueue (
    input  logic            clk,
    input  logic            rst,
    input  logic            pushValid,
    input  mulPkg::productT pushData,
    input  logic            outCredit,
    output logic            outValid,
    output mulPkg::productT product,
    output logic            inCredit
);

    localparam int DEPTH  = `QUEUE_DEPTH;
    localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W  = $clog2(DEPTH + 1);
    localparam int CRED_W = $clog2(`SINK_CREDITS + 1);

    mulPkg::productT mem [DEPTH];
    logic [PTR_W-1:0]  rdPtr;
    logic [PTR_W-1:0]  wrPtr;
    logic [CNT_W-1:0]  count;
    logic [CRED_W-1:0] sinkCredits;
    logic              empty;
    logic              pop;

    // Wraps for any depth
    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Pop decision
    ////////////////////////////////////////////////////////////////////////////

    assign empty = (count == '0);

    // Fall-through when empty, a fresh result may leave in its own cycle
    assign pop      = (!empty || pushValid) && (sinkCredits != '0);
    assign outValid = pop;
    // Each departure frees one slot for the sender
    assign inCredit = pop;
    assign product  = empty ? pushData : mem[rdPtr];

    ////////////////////////////////////////////////////////////////////////////
    // Storage and counters
    ////////////////////////////////////////////////////////////////////////////

    // Bypassed entries are written too, pointers stay aligned
    always_ff @(posedge clk) begin
        if (pushValid) begin
            mem[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rdPtr       <= '0;
            wrPtr       <= '0;
            count       <= '0;
            sinkCredits <= CRED_W'(`SINK_CREDITS);
        end else begin
            if (pushValid) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({pushValid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Sink returns credits, every pop spends one
            case ({outCredit, pop})
                2'b10:   sinkCredits <= sinkCredits + 1'b1;
                2'b01:   sinkCredits <= sinkCredits - 1'b1;
                default: sinkCredits <= sinkCredits;
            endcase
        end
    end

    // Sender pushed without a credit
    assert property (@(posedge clk) disable iff (rst) !(pushValid && count == CNT_W'(DEPTH)))
        else $error("creditQueue: push into full queue");

    // Sink returned more credits than it was granted
    assert property (@(posedge clk) disable iff (rst) sinkCredits <= CRED_W'(`SINK_CREDITS))
        else $error("creditQueue: sink credit overflow");

endmodule

`default_nettype wire

//--- source/approxMultiplier.sv
`timescale 1ns/1ps
`default_nettype none

module approxMultiplier (
    input  logic            clk,
    input  logic            rst,
    input  logic            inValid,
    input  mulPkg::operandT inA,
    input  mulPkg::operandT inB,
    output logic            inCredit,
    output logic            outValid,
    output mulPkg::productT product,
    input  logic            outCredit
);

    // Decode to execute
    logic              pgValid;
    mulPkg::pgPairT    pgBits;
    // Execute to result
    logic              rowValid;
    mulPkg::reduceRowT rowK;
    mulPkg::reduceRowT rowJ;
    // Result to queue
    logic              sumValid;
    mulPkg::productT   sum;

    ////////////////////////////////////////////////////////////////////////////
    // Three-stage datapath and output queue
    ////////////////////////////////////////////////////////////////////////////

    ppDecode uDecode (
        .clk     (clk),
        .rst     (rst),
        .inValid (inValid),
        .inA     (inA),
        .inB     (inB),
        .pgValid (pgValid),
        .pgBits  (pgBits)
    );

    approxReduce uReduce (
        .clk      (clk),
        .rst      (rst),
        .pgValid  (pgValid),
        .pgBits   (pgBits),
        .rowValid (rowValid),
        .rowK     (rowK),
        .rowJ     (rowJ)
    );

    prefixResult uResult (
        .clk      (clk),
        .rst      (rst),
        .rowValid (rowValid),
        .rowK     (rowK),
        .rowJ     (rowJ),
        .sumValid (sumValid),
        .sum      (sum)
    );

    // Credits in both directions live here
    creditQueue uQueue (
        .clk       (clk),
        .rst       (rst),
        .pushValid (sumValid),
        .pushData  (sum),
        .outCredit (outCredit),
        .outValid  (outValid),
        .product   (product),
        .inCredit  (inCredit)
    );

endmodule

`default_nettype wire

//--- tb/approxMultiplierTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mulSettings.svh"

module approxMultiplierTb;

    localparam int CLK_PERIOD   = 4;
    localparam int NUM_TESTS    = 24;
    localparam int SEED         = 41250;
    localparam int IDLE_CYCLES  = 3;
    localparam int HOLD_CYCLES  = 40;
    localparam int DRAIN_CYCLES = 12;
    localparam int MIN_LATENCY  = 3;

    localparam int KIND_ZERO  = 0;
    localparam int KIND_EXACT = 1;
    localparam int KIND_PAIR  = 2;

    logic            clk;
    logic            rst;
    logic            inValid;
    mulPkg::operandT inA;
    mulPkg::operandT inB;
    logic            inCredit;
    logic            outValid;
    mulPkg::productT product;
    logic            outCredit;

    // Stimulus table, one row per operation
    mulPkg::operandT tabA [NUM_TESTS];
    mulPkg::operandT tabB [NUM_TESTS];
    int              tabKind [NUM_TESTS];
    mulPkg::productT tabExp [NUM_TESTS];
    int              tabPartner [NUM_TESTS];

    // Received products and send times
    mulPkg::productT recvProd [NUM_TESTS];
    int              sendCycle [NUM_TESTS];
    // Cycles at which the sink hands back a credit
    int              creditDue [$];

    int cycle;
    int sendIdx;
    int recvCount;
    int senderCredits;
    int inCreditCount;
    int returnedCount;
    int lastDue;
    int holdEnd;
    int passCount;
    int errorCount;
    bit holdActive;
    bit holdDone;
    bit stallSeen;
    bit resumeSeen;

    approxMultiplier dut (
        .clk       (clk),
        .rst       (rst),
        .inValid   (inValid),
        .inA       (inA),
        .inB       (inB),
        .inCredit  (inCredit),
        .outValid  (outValid),
        .product   (product),
        .outCredit (outCredit)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Table
    ////////////////////////////////////////////////////////////////////////////

    task automatic setCase(input int idx, input int a, input int b, input int kind,
                           input int exp, input int partner);
        tabA[idx]       = mulPkg::operandT'(a);
        tabB[idx]       = mulPkg::operandT'(b);
        tabKind[idx]    = kind;
        tabExp[idx]     = mulPkg::productT'(exp);
        tabPartner[idx] = partner;
    endtask

    task automatic fillTable();
        // Zero operand gives zero
        setCase(0, 0, 0, KIND_ZERO, 0, -1);
        setCase(1, 0, 173, KIND_ZERO, 0, -1);
        setCase(2, 219, 0, KIND_ZERO, 0, -1);
        // Power-of-two operand, single non-zero row, exact
        setCase(3, 1, 200, KIND_EXACT, 200, -1);
        setCase(4, 255, 128, KIND_EXACT, 32640, -1);
        setCase(5, 128, 255, KIND_EXACT, 32640, -1);
        setCase(6, 16, 99, KIND_EXACT, 1584, -1);
        setCase(7, 37, 2, KIND_EXACT, 74, -1);
        setCase(8, 64, 255, KIND_EXACT, 16320, -1);
        setCase(9, 255, 1, KIND_EXACT, 255, -1);
        setCase(10, 8, 8, KIND_EXACT, 64, -1);
        setCase(11, 173, 32, KIND_EXACT, 5536, -1);
        // Swapped pairs, value unknown but must match
        setCase(12, 3, 5, KIND_PAIR, 0, 13);
        setCase(13, 5, 3, KIND_PAIR, 0, 12);
        setCase(14, 200, 77, KIND_PAIR, 0, 15);
        setCase(15, 77, 200, KIND_PAIR, 0, 14);
        setCase(16, 123, 231, KIND_PAIR, 0, 17);
        setCase(17, 231, 123, KIND_PAIR, 0, 16);
        setCase(18, 255, 254, KIND_PAIR, 0, 19);
        setCase(19, 254, 255, KIND_PAIR, 0, 18);
        setCase(20, 99, 170, KIND_PAIR, 0, 21);
        setCase(21, 170, 99, KIND_PAIR, 0, 20);
        setCase(22, 2, 128, KIND_EXACT, 256, -1);
        setCase(23, 90, 0, KIND_ZERO, 0, -1);
    endtask

    function automatic string kindName(input int kind);
        if (kind == KIND_ZERO) begin
            return "zero";
        end else if (kind == KIND_EXACT) begin
            return "exact";
        end
        return "pair";
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Result checking
    ////////////////////////////////////////////////////////////////////////////

    task automatic checkResult(input int k, input mulPkg::productT value);
        int partner;
        partner = tabPartner[k];
        recvProd[k] = value;
        if (tabKind[k] == KIND_PAIR && partner > k) begin
            // First of a pair, compared when its mirror arrives
            $display("test %0d %s: %0d * %0d = %0d, held for swap check",
                     k, kindName(tabKind[k]), tabA[k], tabB[k], value);
        end else if (tabKind[k] == KIND_PAIR) begin
            if (value !== recvProd[partner]) begin
                $display("** Error at %0t: product = %0d, expected %0d (swap of test %0d)",
                         $time, value, recvProd[partner], partner);
                errorCount++;
                $display("test %0d pair: %0d * %0d = %0d, wrong", k, tabA[k], tabB[k], value);
            end else begin
                passCount++;
                $display("test %0d pair: %0d * %0d = %0d, ok", k, tabA[k], tabB[k], value);
            end
        end else begin
            if (value !== tabExp[k]) begin
                $display("** Error at %0t: product = %0d, expected %0d (test %0d)",
                         $time, value, tabExp[k], k);
                errorCount++;
                $display("test %0d %s: %0d * %0d = %0d, wrong",
                         k, kindName(tabKind[k]), tabA[k], tabB[k], value);
            end else begin
                passCount++;
                $display("test %0d %s: %0d * %0d = %0d, ok",
                         k, kindName(tabKind[k]), tabA[k], tabB[k], value);
            end
        end
    endtask

    // Outputs only move after a rising edge, so the falling edge sees them settled
    task automatic sampleOutputs();
        int due;
        if (inCredit !== outValid) begin
            $display("At %0t the DUT returned a sender credit out of step with outValid", $time);
            errorCount++;
        end
        if (sendIdx == 0 && (outValid !== 1'b0 || inCredit !== 1'b0)) begin
            $display("At %0t outValid or inCredit was high before any operation", $time);
            errorCount++;
        end
        if (inCredit === 1'b1) begin
            senderCredits++;
            inCreditCount++;
        end
        if (outValid === 1'b1) begin
            if (recvCount >= sendIdx) begin
                $display("At %0t a result arrived with no operation outstanding", $time);
                errorCount++;
            end else begin
                // Sink never granted more than it holds
                if (recvCount + 1 > `SINK_CREDITS + returnedCount) begin
                    $display("At %0t a result was delivered without a sink credit", $time);
                    errorCount++;
                end
                if (cycle - sendCycle[recvCount] < MIN_LATENCY) begin
                    $display("At %0t test %0d came back after %0d cycles, too early",
                             $time, recvCount, cycle - sendCycle[recvCount]);
                    errorCount++;
                end
                checkResult(recvCount, product);
                recvCount++;
                // Random return delay, one credit per cycle at most
                due = cycle + int'($urandom_range(3, 0));
                if (due <= lastDue) begin
                    due = lastDue + 1;
                end
                lastDue = due;
                creditDue.push_back(due);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Sender and sink
    ////////////////////////////////////////////////////////////////////////////

    // Sink withholds credits once, halfway through the table
    task automatic updateHold();
        if (!holdDone && !holdActive && sendIdx >= NUM_TESTS / 2) begin
            holdActive = 1'b1;
            holdEnd = cycle + HOLD_CYCLES;
        end
        if (holdActive && cycle >= holdEnd) begin
            holdActive = 1'b0;
            holdDone = 1'b1;
        end
    endtask

    task automatic driveSender();
        inValid = 1'b0;
        if (cycle > IDLE_CYCLES && sendIdx < NUM_TESTS && senderCredits > 0) begin
            inValid = 1'b1;
            inA = tabA[sendIdx];
            inB = tabB[sendIdx];
            sendCycle[sendIdx] = cycle;
            senderCredits--;
            sendIdx++;
            if (holdDone && stallSeen) begin
                resumeSeen = 1'b1;
            end
        end else if (holdActive && sendIdx < NUM_TESTS && senderCredits == 0) begin
            stallSeen = 1'b1;
        end
    endtask

    task automatic driveSink();
        outCredit = 1'b0;
        if (!holdActive && creditDue.size() > 0) begin
            if (creditDue[0] <= cycle) begin
                void'(creditDue.pop_front());
                outCredit = 1'b1;
                returnedCount++;
            end
        end
    endtask

    task automatic stepCycle();
        @(negedge clk);
        cycle++;
        sampleOutputs();
        updateHold();
        driveSender();
        driveSink();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main flow and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(SEED));
        fillTable();
        rst = 1'b1;
        inValid = 1'b0;
        inA = '0;
        inB = '0;
        outCredit = 1'b0;
        cycle = 0;
        sendIdx = 0;
        recvCount = 0;
        senderCredits = `QUEUE_DEPTH;
        inCreditCount = 0;
        returnedCount = 0;
        lastDue = -1;
        holdEnd = 0;
        passCount = 0;
        errorCount = 0;
        holdActive = 1'b0;
        holdDone = 1'b0;
        stallSeen = 1'b0;
        resumeSeen = 1'b0;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        while (recvCount < NUM_TESTS) begin
            stepCycle();
        end
        // Let the last credits go home, nothing else may arrive
        repeat (DRAIN_CYCLES) begin
            stepCycle();
        end

        if (inCreditCount != recvCount) begin
            $display("DUT returned %0d sender credits for %0d results", inCreditCount, recvCount);
            errorCount++;
        end
        if (!stallSeen) begin
            $display("Sender never ran out of credits while the sink held back");
            errorCount++;
        end
        if (!resumeSeen) begin
            $display("Sender did not resume after sink credits came back");
            errorCount++;
        end

        $display("Tests %0d, checks passed %0d, errors %0d", NUM_TESTS, passCount, errorCount);
        if (errorCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Budget of 20 cycles per operation
    initial begin
        #(NUM_TESTS * 20 * CLK_PERIOD);
        $display("Timeout after %0t, %0d of %0d results arrived", $time, recvCount, NUM_TESTS);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+source
source/mulPkg.sv
source/ppDecode.sv
source/approxReduce.sv
source/prefixResult.sv
source/creditQueue.sv
source/approxMultiplier.sv
tb/approxMultiplierTb.sv

//--- run.sh
#!/bin/sh
# Build and run the approximate multiplier testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module approxMultiplierTb -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" "$LOG"; then
    exit 1
fi
exit 0
